// ==== aluDecoder.sv ====
// combinational ALU function decode from the held instruction fields
// shifts, xor and unsigned compares are reported as illegal
// opcodes other than register or immediate ALU ops decode to add and legal
`timescale 1ns/10ps

module aluDecoder
(
    input  cpuControlPkg::opcode  op,
    input  logic [2:0]            funct3,
    input  logic [6:0]            funct7,
    output cpuControlPkg::aluFunc aluFn,
    output logic                  aluLegal
);

    always_comb
    begin
        // safe defaults, also the answer for loads, stores, branches and nop
        aluFn    = cpuControlPkg::aluAdd;
        aluLegal = 1'b1;

        case (op)
            cpuControlPkg::opRType:
            begin
                case (funct3)
                    // add or sub, chosen by funct7
                    3'b000:
                    begin
                        if (funct7 == cpuControlPkg::funct7Base)
                        begin
                            aluFn = cpuControlPkg::aluAdd;
                        end
                        else if (funct7 == cpuControlPkg::funct7Alt)
                        begin
                            aluFn = cpuControlPkg::aluSub;
                        end
                        else
                        begin
                            aluLegal = 1'b0;
                        end
                    end
                    // slt
                    3'b010:
                    begin
                        aluFn    = cpuControlPkg::aluSlt;
                        aluLegal = (funct7 == cpuControlPkg::funct7Base);
                    end
                    // or
                    3'b110:
                    begin
                        aluFn    = cpuControlPkg::aluOr;
                        aluLegal = (funct7 == cpuControlPkg::funct7Base);
                    end
                    // and
                    3'b111:
                    begin
                        aluFn    = cpuControlPkg::aluAnd;
                        aluLegal = (funct7 == cpuControlPkg::funct7Base);
                    end
                    // sll, sltu, xor, srl/sra not supported
                    default:
                    begin
                        aluLegal = 1'b0;
                    end
                endcase
            end

            cpuControlPkg::opIType:
            begin
                // funct7 bits belong to the immediate here
                case (funct3)
                    3'b000:
                    begin
                        aluFn = cpuControlPkg::aluAdd;
                    end
                    3'b010:
                    begin
                        aluFn = cpuControlPkg::aluSlt;
                    end
                    3'b110:
                    begin
                        aluFn = cpuControlPkg::aluOr;
                    end
                    3'b111:
                    begin
                        aluFn = cpuControlPkg::aluAnd;
                    end
                    // slli, sltiu, xori, srli/srai
                    default:
                    begin
                        aluLegal = 1'b0;
                    end
                endcase
            end

            default:
            begin
                aluFn    = cpuControlPkg::aluAdd;
                aluLegal = 1'b1;
            end
        endcase
    end

endmodule

// ==== controlFsm.sv ====
// Moore FSM sequencing fetch, decode, execute, memory and write-back
// op must stay stable from the end of Fetch until the next Fetch
// memory data is assumed valid one cycle after the address, no wait states
// Error is sticky and only left through reset
`timescale 1ns/10ps

module controlFsm
(
    input  logic                  clk,
    input  logic                  reset,
    input  cpuControlPkg::opcode  op,
    input  cpuControlPkg::aluFunc aluFn,
    input  logic                  aluLegal,
    input  logic                  zero,
    output logic                  pcWrite,
    output logic                  adrSrc,
    output logic                  memWrite,
    output logic                  irWrite,
    output logic                  regWrite,
    output cpuControlPkg::srcSel  resultSrc,
    output cpuControlPkg::srcSel  aluSrcA,
    output cpuControlPkg::srcSel  aluSrcB,
    output cpuControlPkg::srcSel  immSrc,
    output cpuControlPkg::aluFunc aluControl,
    output logic                  trap
);

    cpuControlPkg::ctrlState state;
    cpuControlPkg::ctrlState nextState;

    // state register, reset lands directly in Fetch
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= cpuControlPkg::Fetch;
        end
        else
        begin
            state <= nextState;
        end
    end

    // next-state logic
    always_comb
    begin
        nextState = cpuControlPkg::Error;

        case (state)
            cpuControlPkg::Fetch:
            begin
                nextState = cpuControlPkg::Decode;
            end

            cpuControlPkg::Decode:
            begin
                // opcode class picks the path
                // the decoder flag only matters for ALU ops
                case (op)
                    cpuControlPkg::opLoad,
                    cpuControlPkg::opStore:
                    begin
                        nextState = cpuControlPkg::MemAddr;
                    end
                    cpuControlPkg::opRType:
                    begin
                        nextState = aluLegal ? cpuControlPkg::ExecuteR : cpuControlPkg::Error;
                    end
                    cpuControlPkg::opIType:
                    begin
                        nextState = aluLegal ? cpuControlPkg::ExecuteI : cpuControlPkg::Error;
                    end
                    cpuControlPkg::opBranch:
                    begin
                        nextState = cpuControlPkg::BranchCompare;
                    end
                    // nop goes straight back to fetch
                    cpuControlPkg::opNop:
                    begin
                        nextState = cpuControlPkg::Fetch;
                    end
                    // jal and anything unknown
                    default:
                    begin
                        nextState = cpuControlPkg::Error;
                    end
                endcase
            end

            cpuControlPkg::MemAddr:
            begin
                if (op == cpuControlPkg::opLoad)
                begin
                    nextState = cpuControlPkg::MemRead;
                end
                else if (op == cpuControlPkg::opStore)
                begin
                    nextState = cpuControlPkg::MemStore;
                end
                else
                begin
                    nextState = cpuControlPkg::Error;
                end
            end

            cpuControlPkg::MemRead:
            begin
                nextState = cpuControlPkg::MemWriteBack;
            end

            cpuControlPkg::ExecuteR,
            cpuControlPkg::ExecuteI:
            begin
                nextState = cpuControlPkg::AluWriteBack;
            end

            cpuControlPkg::BranchCompare:
            begin
                nextState = cpuControlPkg::BranchResolve;
            end

            // last cycle of each instruction
            cpuControlPkg::MemWriteBack,
            cpuControlPkg::MemStore,
            cpuControlPkg::AluWriteBack,
            cpuControlPkg::BranchResolve:
            begin
                nextState = cpuControlPkg::Fetch;
            end

            // Error holds, unused encodings fall in here too
            default:
            begin
                nextState = cpuControlPkg::Error;
            end
        endcase
    end

    // Moore output decode
    // everything starts inactive, each state raises only what it needs
    always_comb
    begin
        pcWrite    = 1'b0;
        adrSrc     = 1'b0;
        memWrite   = 1'b0;
        irWrite    = 1'b0;
        regWrite   = 1'b0;
        resultSrc  = cpuControlPkg::resAluOut;
        aluSrcA    = cpuControlPkg::srcAPc;
        aluSrcB    = cpuControlPkg::srcBReg;
        immSrc     = cpuControlPkg::immI;
        aluControl = cpuControlPkg::aluAdd;
        trap       = 1'b0;

        case (state)
            // load instruction, pc + 4 straight onto the result bus
            cpuControlPkg::Fetch:
            begin
                pcWrite    = 1'b1;
                irWrite    = 1'b1;
                aluSrcA    = cpuControlPkg::srcAPc;
                aluSrcB    = cpuControlPkg::srcBFour;
                aluControl = cpuControlPkg::aluAdd;
                resultSrc  = cpuControlPkg::resAluResult;
            end

            // old pc + B immediate, kept in ALUOut for a later branch
            cpuControlPkg::Decode:
            begin
                aluSrcA    = cpuControlPkg::srcAOldPc;
                aluSrcB    = cpuControlPkg::srcBImm;
                immSrc     = cpuControlPkg::immB;
                aluControl = cpuControlPkg::aluAdd;
            end

            // rs1 + offset, immediate format depends on load or store
            cpuControlPkg::MemAddr:
            begin
                aluSrcA    = cpuControlPkg::srcAReg;
                aluSrcB    = cpuControlPkg::srcBImm;
                aluControl = cpuControlPkg::aluAdd;
                immSrc     = (op == cpuControlPkg::opStore) ? cpuControlPkg::immS
                                                            : cpuControlPkg::immI;
            end

            // address from ALUOut onto the memory port
            cpuControlPkg::MemRead:
            begin
                adrSrc    = 1'b1;
                resultSrc = cpuControlPkg::resAluOut;
            end

            cpuControlPkg::MemWriteBack:
            begin
                regWrite  = 1'b1;
                resultSrc = cpuControlPkg::resData;
            end

            cpuControlPkg::MemStore:
            begin
                adrSrc    = 1'b1;
                memWrite  = 1'b1;
                resultSrc = cpuControlPkg::resAluOut;
            end

            // rs1 op rs2
            cpuControlPkg::ExecuteR:
            begin
                aluSrcA    = cpuControlPkg::srcAReg;
                aluSrcB    = cpuControlPkg::srcBReg;
                aluControl = aluFn;
            end

            // rs1 op imm
            cpuControlPkg::ExecuteI:
            begin
                aluSrcA    = cpuControlPkg::srcAReg;
                aluSrcB    = cpuControlPkg::srcBImm;
                immSrc     = cpuControlPkg::immI;
                aluControl = aluFn;
            end

            cpuControlPkg::AluWriteBack:
            begin
                regWrite  = 1'b1;
                resultSrc = cpuControlPkg::resAluOut;
            end

            // rs1 - rs2, zero flag valid next cycle
            cpuControlPkg::BranchCompare:
            begin
                aluSrcA    = cpuControlPkg::srcAReg;
                aluSrcB    = cpuControlPkg::srcBReg;
                aluControl = cpuControlPkg::aluSub;
            end

            // ALUOut still holds the target from Decode
            cpuControlPkg::BranchResolve:
            begin
                pcWrite   = zero;
                resultSrc = cpuControlPkg::resAluOut;
            end

            default:
            begin
                trap = 1'b1;
            end
        endcase
    end

endmodule

// ==== controller.f ====
+incdir+.
cpuControlPkg.sv
aluDecoder.sv
controlFsm.sv
controller.sv
controllerTb.sv

// ==== controller.sv ====
// top of the multicycle control unit, decoder beside the FSM
// op, funct3 and funct7 come from the instruction register and must stay stable
// all outputs are plain levels, no handshake with the datapath
`timescale 1ns/10ps

module controller
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [6:0]            op,
    input  logic [2:0]            funct3,
    input  logic [6:0]            funct7,
    input  logic                  zero,
    output logic                  pcWrite,
    output logic                  adrSrc,
    output logic                  memWrite,
    output logic                  irWrite,
    output logic                  regWrite,
    output cpuControlPkg::srcSel  resultSrc,
    output cpuControlPkg::srcSel  aluSrcA,
    output cpuControlPkg::srcSel  aluSrcB,
    output cpuControlPkg::srcSel  immSrc,
    output cpuControlPkg::aluFunc aluControl,
    output logic                  trap
);

    cpuControlPkg::aluFunc aluFn;
    logic                  aluLegal;

    // raw opcode bits viewed as the opcode type, unknown values pass through
    aluDecoder aluDec
    (
        .op       (cpuControlPkg::opcode'(op)),
        .funct3   (funct3),
        .funct7   (funct7),
        .aluFn    (aluFn),
        .aluLegal (aluLegal)
    );

    controlFsm fsm
    (
        .clk        (clk),
        .reset      (reset),
        .op         (cpuControlPkg::opcode'(op)),
        .aluFn      (aluFn),
        .aluLegal   (aluLegal),
        .zero       (zero),
        .pcWrite    (pcWrite),
        .adrSrc     (adrSrc),
        .memWrite   (memWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .resultSrc  (resultSrc),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .immSrc     (immSrc),
        .aluControl (aluControl),
        .trap       (trap)
    );

endmodule

// ==== controllerTbTable.svh ====
// instruction cases for the control unit testbench, included inside controllerTb
// cycle fields count from 1 at Fetch, 0 means the enable never rises
// trap rows end in Error and need a reset before the next row
`ifndef controllerTbTableSvh
`define controllerTbTableSvh

// one instruction case and what the sequence must look like
typedef struct packed
{
    logic [6:0]            op;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  zero;
    int                    cycles;
    cpuControlPkg::aluFunc expAlu;
    int                    adrCycle;
    int                    memCycle;
    int                    regCycle;
    logic                  expTrap;
} caseRow;

localparam int maxCases = 24;

caseRow caseTable [maxCases];
int     numCases = 0;

// append one row to the table
task automatic addCase(input logic [6:0] rowOp, input logic [2:0] rowF3,
                       input logic [6:0] rowF7, input logic rowZero, input int rowCycles,
                       input cpuControlPkg::aluFunc rowAlu, input int rowAdr,
                       input int rowMem, input int rowReg, input logic rowTrap);
    caseTable[numCases] = {rowOp, rowF3, rowF7, rowZero, rowCycles, rowAlu,
                           rowAdr, rowMem, rowReg, rowTrap};
    numCases = numCases + 1;
endtask

task automatic fillCaseTable();
    // register ops, write-back in cycle 4
    addCase(cpuControlPkg::opRType, 3'b000, cpuControlPkg::funct7Base, 1'b0, 4,
            cpuControlPkg::aluAdd, 0, 0, 4, 1'b0);
    addCase(cpuControlPkg::opRType, 3'b000, cpuControlPkg::funct7Alt, 1'b0, 4,
            cpuControlPkg::aluSub, 0, 0, 4, 1'b0);
    addCase(cpuControlPkg::opRType, 3'b111, cpuControlPkg::funct7Base, 1'b0, 4,
            cpuControlPkg::aluAnd, 0, 0, 4, 1'b0);
    addCase(cpuControlPkg::opRType, 3'b110, cpuControlPkg::funct7Base, 1'b0, 4,
            cpuControlPkg::aluOr, 0, 0, 4, 1'b0);
    addCase(cpuControlPkg::opRType, 3'b010, cpuControlPkg::funct7Base, 1'b0, 4,
            cpuControlPkg::aluSlt, 0, 0, 4, 1'b0);
    // immediate ops, funct7 is immediate bits here so any value goes
    addCase(cpuControlPkg::opIType, 3'b000, 7'h55, 1'b0, 4,
            cpuControlPkg::aluAdd, 0, 0, 4, 1'b0);
    addCase(cpuControlPkg::opIType, 3'b111, 7'h7f, 1'b0, 4,
            cpuControlPkg::aluAnd, 0, 0, 4, 1'b0);
    addCase(cpuControlPkg::opIType, 3'b110, 7'h01, 1'b0, 4,
            cpuControlPkg::aluOr, 0, 0, 4, 1'b0);
    addCase(cpuControlPkg::opIType, 3'b010, cpuControlPkg::funct7Alt, 1'b0, 4,
            cpuControlPkg::aluSlt, 0, 0, 4, 1'b0);
    // lw and sw, address computed with add in MemAddr
    addCase(cpuControlPkg::opLoad, 3'b010, 7'h00, 1'b0, 5,
            cpuControlPkg::aluAdd, 4, 0, 5, 1'b0);
    addCase(cpuControlPkg::opStore, 3'b010, 7'h00, 1'b0, 4,
            cpuControlPkg::aluAdd, 4, 4, 0, 1'b0);
    // beq taken and not taken
    addCase(cpuControlPkg::opBranch, 3'b000, 7'h00, 1'b1, 4,
            cpuControlPkg::aluSub, 0, 0, 0, 1'b0);
    addCase(cpuControlPkg::opBranch, 3'b000, 7'h00, 1'b0, 4,
            cpuControlPkg::aluSub, 0, 0, 0, 1'b0);
    addCase(cpuControlPkg::opNop, 3'b000, 7'h00, 1'b0, 2,
            cpuControlPkg::aluAdd, 0, 0, 0, 1'b0);
    // xor is not supported
    addCase(cpuControlPkg::opRType, 3'b100, cpuControlPkg::funct7Base, 1'b0, 0,
            cpuControlPkg::aluAdd, 0, 0, 0, 1'b1);
    addCase(cpuControlPkg::opRType, 3'b000, cpuControlPkg::funct7Base, 1'b0, 4,
            cpuControlPkg::aluAdd, 0, 0, 4, 1'b0);
    // jal opcode
    addCase(7'b1101111, 3'b000, 7'h00, 1'b0, 0,
            cpuControlPkg::aluAdd, 0, 0, 0, 1'b1);
    addCase(cpuControlPkg::opLoad, 3'b010, 7'h00, 1'b0, 5,
            cpuControlPkg::aluAdd, 4, 0, 5, 1'b0);
endtask

`endif

// ==== controllerTb.sv ====
// table-driven testbench for the multicycle control unit
// inputs change only on the edge that ends Fetch
// outputs are sampled on the falling edge
`timescale 1ns/10ps

module controllerTb;

    localparam int resetCycles  = 8;
    localparam int fetchTimeout = 16;
    localparam int trapHold     = 10;

    logic                  clk = 1'b0;
    logic                  reset;
    logic [6:0]            op;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  zero;
    logic                  pcWrite;
    logic                  adrSrc;
    logic                  memWrite;
    logic                  irWrite;
    logic                  regWrite;
    cpuControlPkg::srcSel  resultSrc;
    cpuControlPkg::srcSel  aluSrcA;
    cpuControlPkg::srcSel  aluSrcB;
    cpuControlPkg::srcSel  immSrc;
    cpuControlPkg::aluFunc aluControl;
    logic                  trap;
    int                    row;

    `include "controllerTbTable.svh"

    controller dut
    (
        .clk        (clk),
        .reset      (reset),
        .op         (op),
        .funct3     (funct3),
        .funct7     (funct7),
        .zero       (zero),
        .pcWrite    (pcWrite),
        .adrSrc     (adrSrc),
        .memWrite   (memWrite),
        .irWrite    (irWrite),
        .regWrite   (regWrite),
        .resultSrc  (resultSrc),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .immSrc     (immSrc),
        .aluControl (aluControl),
        .trap       (trap)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic compareValue(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic stopOnHang(input string what);
        $display("%s: no fetch within %0d cycles at %0t", what, fetchTimeout, $time);
        $display("Regression failed");
        $fatal(1, "stopped on timeout");
    endtask

    // state expected in cycle k of a row, counted from 1 at Fetch
    function automatic cpuControlPkg::ctrlState expectedState(input int r, input int k);
        logic [6:0] rowOp;
        rowOp         = caseTable[r].op;
        expectedState = cpuControlPkg::Fetch;
        if (k == 2)
        begin
            expectedState = cpuControlPkg::Decode;
        end
        else if (caseTable[r].expTrap && (k >= 3))
        begin
            // illegal rows stay in Error
            expectedState = cpuControlPkg::Error;
        end
        else if (k == 3)
        begin
            case (rowOp)
                cpuControlPkg::opLoad,
                cpuControlPkg::opStore:  expectedState = cpuControlPkg::MemAddr;
                cpuControlPkg::opRType:  expectedState = cpuControlPkg::ExecuteR;
                cpuControlPkg::opIType:  expectedState = cpuControlPkg::ExecuteI;
                cpuControlPkg::opBranch: expectedState = cpuControlPkg::BranchCompare;
                default:                 expectedState = cpuControlPkg::Fetch;
            endcase
        end
        else if (k == 4)
        begin
            case (rowOp)
                cpuControlPkg::opLoad:   expectedState = cpuControlPkg::MemRead;
                cpuControlPkg::opStore:  expectedState = cpuControlPkg::MemStore;
                cpuControlPkg::opRType,
                cpuControlPkg::opIType:  expectedState = cpuControlPkg::AluWriteBack;
                cpuControlPkg::opBranch: expectedState = cpuControlPkg::BranchResolve;
                default:                 expectedState = cpuControlPkg::Fetch;
            endcase
        end
        else if ((k == 5) && (rowOp == cpuControlPkg::opLoad))
        begin
            expectedState = cpuControlPkg::MemWriteBack;
        end
    endfunction

    // select outputs from the state table
    // unlisted selects sit at their zero encoding
    task automatic checkSelects(input cpuControlPkg::ctrlState s, input logic isStore);
        cpuControlPkg::srcSel expRes;
        cpuControlPkg::srcSel expA;
        cpuControlPkg::srcSel expB;
        cpuControlPkg::srcSel expImm;
        expRes = cpuControlPkg::resAluOut;
        expA   = cpuControlPkg::srcAPc;
        expB   = cpuControlPkg::srcBReg;
        expImm = cpuControlPkg::immI;
        case (s)
            cpuControlPkg::Fetch:
            begin
                expB   = cpuControlPkg::srcBFour;
                expRes = cpuControlPkg::resAluResult;
            end
            cpuControlPkg::Decode:
            begin
                expA   = cpuControlPkg::srcAOldPc;
                expB   = cpuControlPkg::srcBImm;
                expImm = cpuControlPkg::immB;
            end
            cpuControlPkg::MemAddr:
            begin
                expA   = cpuControlPkg::srcAReg;
                expB   = cpuControlPkg::srcBImm;
                expImm = isStore ? cpuControlPkg::immS : cpuControlPkg::immI;
            end
            cpuControlPkg::MemWriteBack:
            begin
                expRes = cpuControlPkg::resData;
            end
            cpuControlPkg::ExecuteR,
            cpuControlPkg::BranchCompare:
            begin
                expA = cpuControlPkg::srcAReg;
            end
            cpuControlPkg::ExecuteI:
            begin
                expA = cpuControlPkg::srcAReg;
                expB = cpuControlPkg::srcBImm;
            end
            // read, store, write-back, resolve and Error keep the defaults
            default:
            begin
            end
        endcase
        compareValue("resultSrc", 32'(resultSrc), 32'(expRes));
        compareValue("aluSrcA", 32'(aluSrcA), 32'(expA));
        compareValue("aluSrcB", 32'(aluSrcB), 32'(expB));
        compareValue("immSrc", 32'(immSrc), 32'(expImm));
    endtask

    // Fetch is the same for every instruction
    task automatic checkFetchCycle();
        compareValue("pcWrite", 32'(pcWrite), 32'(1'b1));
        compareValue("irWrite", 32'(irWrite), 32'(1'b1));
        compareValue("memWrite", 32'(memWrite), 32'(1'b0));
        compareValue("regWrite", 32'(regWrite), 32'(1'b0));
        compareValue("adrSrc", 32'(adrSrc), 32'(1'b0));
        compareValue("trap", 32'(trap), 32'(1'b0));
        compareValue("aluControl", 32'(aluControl), 32'(cpuControlPkg::aluAdd));
        checkSelects(cpuControlPkg::Fetch, 1'b0);
    endtask

    // expected enables for cycle k >= 2 of a row
    task automatic checkEnables(input int r, input int k);
        logic                  isBranch;
        logic                  expPc;
        logic                  expTrap;
        cpuControlPkg::aluFunc expAlu;
        isBranch = (caseTable[r].op == cpuControlPkg::opBranch);
        // only BranchResolve writes the pc after Fetch
        expPc    = isBranch && (k == 4) && caseTable[r].zero;
        expTrap  = caseTable[r].expTrap && (k >= 3);
        // the third cycle carries the decoded or fixed ALU function
        expAlu   = (k == 3) ? caseTable[r].expAlu : cpuControlPkg::aluAdd;
        compareValue("irWrite", 32'(irWrite), 32'(1'b0));
        compareValue("pcWrite", 32'(pcWrite), 32'(expPc));
        compareValue("adrSrc", 32'(adrSrc), 32'(k == caseTable[r].adrCycle));
        compareValue("memWrite", 32'(memWrite), 32'(k == caseTable[r].memCycle));
        compareValue("regWrite", 32'(regWrite), 32'(k == caseTable[r].regCycle));
        compareValue("trap", 32'(trap), 32'(expTrap));
        compareValue("aluControl", 32'(aluControl), 32'(expAlu));
        checkSelects(expectedState(r, k), caseTable[r].op == cpuControlPkg::opStore);
    endtask

    // falling edges until irWrite shows Fetch
    task automatic waitForFetch(input string what);
        int   n;
        logic found;
        n     = 0;
        found = 1'b0;
        while (!found && n < fetchTimeout)
        begin
            @(negedge clk);
            n     = n + 1;
            found = (irWrite === 1'b1);
        end
        if (!found)
        begin
            stopOnHang(what);
        end
        checkFetchCycle();
    endtask

    task automatic applyReset();
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        // async reset already forced Fetch
        checkFetchCycle();
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
        waitForFetch("first fetch after reset");
    endtask

    // instruction fields change on the edge leaving Fetch
    task automatic driveRow(input int r);
        @(posedge clk);
        op     <= caseTable[r].op;
        funct3 <= caseTable[r].funct3;
        funct7 <= caseTable[r].funct7;
        zero   <= caseTable[r].zero;
    endtask

    // runs from one Fetch falling edge to the next
    task automatic runInstruction(input int r);
        int   k;
        logic fetched;
        driveRow(r);
        k       = 1;
        fetched = 1'b0;
        while (!fetched && k < fetchTimeout)
        begin
            @(negedge clk);
            k = k + 1;
            if (irWrite === 1'b1)
            begin
                fetched = 1'b1;
            end
            else
            begin
                checkEnables(r, k);
            end
        end
        if (!fetched)
        begin
            stopOnHang($sformatf("row %0d with op %b", r, caseTable[r].op));
        end
        compareValue("cycle count", 32'(k - 1), 32'(caseTable[r].cycles));
        checkFetchCycle();
    endtask

    // trap follows Decode and holds until a reset
    task automatic runTrap(input int r);
        int k;
        driveRow(r);
        for (k = 2; k <= 2 + trapHold; k++)
        begin
            @(negedge clk);
            checkEnables(r, k);
        end
        applyReset();
    endtask

    initial
    begin
        reset  <= 1'b1;
        op     <= cpuControlPkg::opNop;
        funct3 <= 3'b000;
        funct7 <= 7'h00;
        zero   <= 1'b0;
        fillCaseTable();
        applyReset();
        for (row = 0; row < numCases; row++)
        begin
            if (caseTable[row].expTrap)
            begin
                runTrap(row);
            end
            else
            begin
                runInstruction(row);
            end
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== cpuControlPkg.sv ====
// shared types and encodings for the multicycle RV32I-subset control unit
// only lw, sw, register and immediate ALU ops, beq and the all-zero nop are decoded
// select encodings must match the datapath multiplexers
package cpuControlPkg;

    // one state per cycle of the multicycle sequence
    typedef enum logic [3:0]
    {
        Fetch         = 4'd0,
        Decode        = 4'd1,
        MemAddr       = 4'd2,
        MemRead       = 4'd3,
        MemWriteBack  = 4'd4,
        MemStore      = 4'd5,
        ExecuteR      = 4'd6,
        ExecuteI      = 4'd7,
        AluWriteBack  = 4'd8,
        BranchCompare = 4'd9,
        BranchResolve = 4'd10,
        Error         = 4'd15
    } ctrlState;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0]
    {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRType  = 7'b0110011,
        opIType  = 7'b0010011,
        opBranch = 7'b1100011,
        opNop    = 7'b0000000
    } opcode;

    // ALU operation codes as seen by the datapath ALU
    typedef enum logic [2:0]
    {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluFunc;

    // common width of all multiplexer selects
    typedef logic [1:0] srcSel;

    // ALU operand A
    localparam srcSel srcAPc    = 2'b00;
    localparam srcSel srcAOldPc = 2'b01;
    localparam srcSel srcAReg   = 2'b10;

    // ALU operand B
    localparam srcSel srcBReg  = 2'b00;
    localparam srcSel srcBImm  = 2'b01;
    localparam srcSel srcBFour = 2'b10;

    // result bus source
    // resAluOut is the registered ALU output, resAluResult the live one
    localparam srcSel resAluOut    = 2'b00;
    localparam srcSel resData      = 2'b01;
    localparam srcSel resAluResult = 2'b10;

    // immediate extender format
    localparam srcSel immI = 2'b00;
    localparam srcSel immS = 2'b01;
    localparam srcSel immB = 2'b10;

    // funct7 patterns of the kept register ops
    localparam logic [6:0] funct7Base = 7'b0000000;
    localparam logic [6:0] funct7Alt  = 7'b0100000;

endpackage

// ==== runSim.sh ====
#!/bin/sh
# compiles the control unit testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f controller.f --top-module controllerTb -o controllerSim

status=0
output=$(./obj_dir/controllerSim) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Regression passed"; then
    exit 0
fi
echo "simulation exit status $status"
exit 1
